// ==== files.f ====
rtl/sd_hub_pkg.sv
rtl/zx_sd_port.sv
rtl/avr_sd_port.sv
rtl/sd_owner_mux.sv
rtl/spi_shifter.sv
rtl/sd_spi_hub.sv
verification/sd_card_model.sv
verification/tb_sd_spi_hub.sv

// ==== rtl/avr_sd_port.sv ====
/*
 * microcontroller side sd port
 * card lock, chip select, byte starts and the read-back byte
 */

`timescale 1ns/10ps
`default_nettype none

module avr_sd_port
(
	input  logic                           fclk,
	input  logic                           reset,
	input  logic                           avr_lock_claim,
	input  logic                           avr_cs_n,
	input  logic                           avr_start,
	input  logic [sd_hub_pkg::BYTE_W-1:0]  avr_datain,
	input  logic                           busy,
	input  logic                           shift_start,
	input  logic                           avr_done,
	input  logic [sd_hub_pkg::BYTE_W-1:0]  rx_data,
	output sd_hub_pkg::sd_cmd_t            avr_cmd,
	output logic                           avr_lock_grant,
	output logic [sd_hub_pkg::BYTE_W-1:0]  avr_dataout
);

	logic                          cs_n_reg;
	logic                          start_reg;
	logic [sd_hub_pkg::BYTE_W-1:0] data_reg;

	//////////////////////////////
	// lock
	//////////////////////////////

	// grant waits for an idle shifter, release is immediate
	always_ff @(posedge fclk)
	begin
		if (reset)
			avr_lock_grant <= 1'b0;
		else if (!avr_lock_claim)
			avr_lock_grant <= 1'b0;
		else if (!shift_start && !busy)
			avr_lock_grant <= 1'b1;
	end

	//////////////////////////////
	// command capture
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			cs_n_reg  <= 1'b1;
			start_reg <= 1'b0;
		end
		else
		begin
			cs_n_reg  <= avr_cs_n;
			start_reg <= avr_start;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (avr_start)
			data_reg <= avr_datain;
	end

	// result of the last microcontroller transfer
	always_ff @(posedge fclk)
	begin
		if (reset)
			avr_dataout <= '1;
		else if (avr_done)
			avr_dataout <= rx_data;
	end

	always_comb
	begin
		avr_cmd.cs_n  = cs_n_reg;
		avr_cmd.start = start_reg;
		avr_cmd.data  = data_reg;
	end

endmodule

`default_nettype wire

// ==== rtl/sd_hub_pkg.sv ====
/*
 * sd card hub shared definitions
 * transfer command word, owner encoding and byte width
 */

`default_nettype none

package sd_hub_pkg;

	// width of one spi transfer byte
	localparam int BYTE_W = 8;

	// command word from one side port toward the combiner
	typedef struct packed
	{
		logic              cs_n;
		logic              start;
		logic [BYTE_W-1:0] data;
	} sd_cmd_t;

	// which master owns the card or the byte in flight
	typedef enum logic
	{
		OWNER_ZX  = 1'b0,
		OWNER_AVR = 1'b1
	} sd_owner_t;

endpackage

`default_nettype wire

// ==== rtl/sd_owner_mux.sv ====
/*
 * sd command combiner
 * picks the owning side, gates its starts and routes done back
 */

`timescale 1ns/10ps
`default_nettype none

module sd_owner_mux
(
	input  logic                           fclk,
	input  logic                           reset,
	input  sd_hub_pkg::sd_cmd_t            zx_cmd,
	input  sd_hub_pkg::sd_cmd_t            avr_cmd,
	input  logic                           avr_lock_grant,
	input  logic                           busy,
	input  logic                           done,
	output logic                           sdcs_n,
	output logic                           shift_start,
	output logic [sd_hub_pkg::BYTE_W-1:0]  shift_data,
	output logic                           zx_done,
	output logic                           avr_done
);

	sd_hub_pkg::sd_owner_t owner;
	sd_hub_pkg::sd_owner_t xfer_owner;
	sd_hub_pkg::sd_cmd_t   sel_cmd;

	// the grant alone decides who owns the card
	always_comb
	begin
		if (avr_lock_grant)
			owner = sd_hub_pkg::OWNER_AVR;
		else
			owner = sd_hub_pkg::OWNER_ZX;
	end

	always_comb
	begin
		if (owner == sd_hub_pkg::OWNER_AVR)
			sel_cmd = avr_cmd;
		else
			sel_cmd = zx_cmd;
	end

	assign sdcs_n      = sel_cmd.cs_n;
	// starts from the other side or on a busy shifter are lost
	assign shift_start = sel_cmd.start & ~busy;
	assign shift_data  = sel_cmd.data;

	// owner of the byte in flight, survives a lock release
	always_ff @(posedge fclk)
	begin
		if (reset)
			xfer_owner <= sd_hub_pkg::OWNER_ZX;
		else if (shift_start)
			xfer_owner <= owner;
	end

	assign zx_done  = done & (xfer_owner == sd_hub_pkg::OWNER_ZX);
	assign avr_done = done & (xfer_owner == sd_hub_pkg::OWNER_AVR);

endmodule

`default_nettype wire

// ==== rtl/sd_spi_hub.sv ====
/*
 * shared sd card spi hub
 * z80 port and microcontroller port share one shifter
 */

`timescale 1ns/10ps
`default_nettype none

module sd_spi_hub
#(
	parameter int HALF_PERIOD = 2
)
(
	input  logic                           fclk,
	input  logic                           reset,
	// z80 side
	input  logic                           zx_cs_n_val,
	input  logic                           zx_cs_n_stb,
	input  logic                           zx_start,
	input  logic [sd_hub_pkg::BYTE_W-1:0]  zx_datain,
	output logic [sd_hub_pkg::BYTE_W-1:0]  zx_dataout,
	// microcontroller side
	input  logic                           avr_lock_claim,
	input  logic                           avr_cs_n,
	input  logic                           avr_start,
	input  logic [sd_hub_pkg::BYTE_W-1:0]  avr_datain,
	output logic                           avr_lock_grant,
	output logic [sd_hub_pkg::BYTE_W-1:0]  avr_dataout,
	// card pins
	output logic                           sdcs_n,
	output logic                           sdclk,
	output logic                           sddo,
	input  logic                           sddi,
	output logic                           sd_busy
);

	sd_hub_pkg::sd_cmd_t           zx_cmd;
	sd_hub_pkg::sd_cmd_t           avr_cmd;
	logic                          shift_start;
	logic [sd_hub_pkg::BYTE_W-1:0] shift_data;
	logic [sd_hub_pkg::BYTE_W-1:0] rx_data;
	logic                          done;
	logic                          zx_done;
	logic                          avr_done;

	zx_sd_port zx_sd_port_inst
	(
		.fclk        (fclk),
		.reset       (reset),
		.zx_cs_n_val (zx_cs_n_val),
		.zx_cs_n_stb (zx_cs_n_stb),
		.zx_start    (zx_start),
		.zx_datain   (zx_datain),
		.zx_done     (zx_done),
		.rx_data     (rx_data),
		.zx_cmd      (zx_cmd),
		.zx_dataout  (zx_dataout)
	);

	avr_sd_port avr_sd_port_inst
	(
		.fclk           (fclk),
		.reset          (reset),
		.avr_lock_claim (avr_lock_claim),
		.avr_cs_n       (avr_cs_n),
		.avr_start      (avr_start),
		.avr_datain     (avr_datain),
		.busy           (sd_busy),
		.shift_start    (shift_start),
		.avr_done       (avr_done),
		.rx_data        (rx_data),
		.avr_cmd        (avr_cmd),
		.avr_lock_grant (avr_lock_grant),
		.avr_dataout    (avr_dataout)
	);

	sd_owner_mux sd_owner_mux_inst
	(
		.fclk           (fclk),
		.reset          (reset),
		.zx_cmd         (zx_cmd),
		.avr_cmd        (avr_cmd),
		.avr_lock_grant (avr_lock_grant),
		.busy           (sd_busy),
		.done           (done),
		.sdcs_n         (sdcs_n),
		.shift_start    (shift_start),
		.shift_data     (shift_data),
		.zx_done        (zx_done),
		.avr_done       (avr_done)
	);

	spi_shifter
	#(
		.HALF_PERIOD (HALF_PERIOD)
	)
	spi_shifter_inst
	(
		.fclk        (fclk),
		.reset       (reset),
		.shift_start (shift_start),
		.shift_data  (shift_data),
		.sddi        (sddi),
		.sdclk       (sdclk),
		.sddo        (sddo),
		.busy        (sd_busy),
		.done        (done),
		.rx_data     (rx_data)
	);

endmodule

`default_nettype wire

// ==== rtl/spi_shifter.sv ====
/*
 * spi mode 0 byte shifter, msb first
 * sdclk half period set by HALF_PERIOD in fclk cycles
 */

`timescale 1ns/10ps
`default_nettype none

module spi_shifter
#(
	parameter int HALF_PERIOD = 2
)
(
	input  logic                           fclk,
	input  logic                           reset,
	input  logic                           shift_start,
	input  logic [sd_hub_pkg::BYTE_W-1:0]  shift_data,
	input  logic                           sddi,
	output logic                           sdclk,
	output logic                           sddo,
	output logic                           busy,
	output logic                           done,
	output logic [sd_hub_pkg::BYTE_W-1:0]  rx_data
);

	localparam int DIV_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;
	localparam int BIT_W = $clog2(sd_hub_pkg::BYTE_W);

	logic [DIV_W-1:0]              div_cnt;
	logic [BIT_W-1:0]              bit_cnt;
	logic [sd_hub_pkg::BYTE_W-1:0] shreg;

	logic half_end;

	assign half_end = (div_cnt == DIV_W'(HALF_PERIOD - 1));

	//////////////////////////////
	// control and waveform
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			busy    <= 1'b0;
			done    <= 1'b0;
			sdclk   <= 1'b0;
			sddo    <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				if (shift_start)
				begin
					// first bit goes out before the first rising edge
					busy    <= 1'b1;
					sddo    <= shift_data[sd_hub_pkg::BYTE_W-1];
					div_cnt <= '0;
					bit_cnt <= '0;
				end
			end
			else if (!half_end)
				div_cnt <= div_cnt + 1'b1;
			else
			begin
				div_cnt <= '0;
				sdclk   <= ~sdclk;
				if (sdclk)
				begin
					if (bit_cnt == BIT_W'(sd_hub_pkg::BYTE_W - 1))
					begin
						busy <= 1'b0;
						done <= 1'b1;
					end
					else
					begin
						bit_cnt <= bit_cnt + 1'b1;
						// next tx bit while sdclk is low
						sddo    <= shreg[sd_hub_pkg::BYTE_W-1];
					end
				end
			end
		end
	end

	// loads on start, shifts in sddi on each rising sdclk
	always_ff @(posedge fclk)
	begin
		if (!busy && shift_start)
			shreg <= shift_data;
		else if (busy && half_end && !sdclk)
			shreg <= {shreg[sd_hub_pkg::BYTE_W-2:0], sddi};
	end

	assign rx_data = shreg;

endmodule

`default_nettype wire

// ==== rtl/zx_sd_port.sv ====
/*
 * z80 side sd port
 * holds chip select, captures byte starts and keeps the read-back byte
 */

`timescale 1ns/10ps
`default_nettype none

module zx_sd_port
(
	input  logic                           fclk,
	input  logic                           reset,
	input  logic                           zx_cs_n_val,
	input  logic                           zx_cs_n_stb,
	input  logic                           zx_start,
	input  logic [sd_hub_pkg::BYTE_W-1:0]  zx_datain,
	input  logic                           zx_done,
	input  logic [sd_hub_pkg::BYTE_W-1:0]  rx_data,
	output sd_hub_pkg::sd_cmd_t            zx_cmd,
	output logic [sd_hub_pkg::BYTE_W-1:0]  zx_dataout
);

	logic                          cs_n_reg;
	logic                          start_reg;
	logic [sd_hub_pkg::BYTE_W-1:0] data_reg;

	// chip select only moves on its strobe
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			cs_n_reg  <= 1'b1;
			start_reg <= 1'b0;
		end
		else
		begin
			if (zx_cs_n_stb)
				cs_n_reg <= zx_cs_n_val;
			start_reg <= zx_start;
		end
	end

	// byte to send, taken with the start
	always_ff @(posedge fclk)
	begin
		if (zx_start)
			data_reg <= zx_datain;
	end

	// read-back of the last z80 transfer
	always_ff @(posedge fclk)
	begin
		if (reset)
			zx_dataout <= '1;
		else if (zx_done)
			zx_dataout <= rx_data;
	end

	always_comb
	begin
		zx_cmd.cs_n  = cs_n_reg;
		zx_cmd.start = start_reg;
		zx_cmd.data  = data_reg;
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the sd spi hub testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -Wno-fatal \
	--top-module tb_sd_spi_hub \
	-f files.f \
	-o tb_sd_spi_hub
./obj_dir/tb_sd_spi_hub

// ==== verification/sd_card_model.sv ====
/*
 * behavioural sd card for the spi hub testbench
 * answers with a preset byte and records the bits it receives
 */

`timescale 1ns/10ps
`default_nettype none

module sd_card_model
(
	input  logic       sdcs_n,
	input  logic       sdclk,
	input  logic       sddo,
	input  logic [7:0] preset,
	output logic       sddi,
	output logic [7:0] rx_byte,
	output int         rise_count
);

	logic [2:0] out_idx = 3'd0;
	logic [7:0] rx_shreg = 8'h00;
	int         rises = 0;

	// msb first, wraps to the msb of the next preset after 8 bits
	assign sddi = sdcs_n ? 1'b1 : preset[3'd7 - out_idx];

	always @(negedge sdclk)
	begin
		if (!sdcs_n)
			out_idx <= out_idx + 3'd1;
	end

	// host data is stable around the rising edge
	always @(posedge sdclk)
	begin
		rx_shreg <= {rx_shreg[6:0], sddo};
		rises    <= rises + 1;
	end

	assign rx_byte    = rx_shreg;
	assign rise_count = rises;

endmodule

`default_nettype wire

// ==== verification/tb_sd_spi_hub.sv ====
/*
 * testbench for the shared sd card spi hub
 * z80 and microcontroller transfers, card lock, deferred grant and release
 */

`timescale 1ns/10ps
`default_nettype none

module tb_sd_spi_hub;

	localparam int HALF_PERIOD = 2;
	localparam int XFER_COUNT  = 5;
	// transfers plus reset, lock steps and idle windows
	localparam int WATCHDOG_CYCLES = XFER_COUNT * (20 + 16 * HALF_PERIOD) + 120;

	logic        fclk;
	logic        reset;
	logic        zx_cs_n_val;
	logic        zx_cs_n_stb;
	logic        zx_start;
	logic [7:0]  zx_datain;
	logic [7:0]  zx_dataout;
	logic        avr_lock_claim;
	logic        avr_cs_n;
	logic        avr_start;
	logic [7:0]  avr_datain;
	logic        avr_lock_grant;
	logic [7:0]  avr_dataout;
	logic        sdcs_n;
	logic        sdclk;
	logic        sddo;
	logic        sddi;
	logic        sd_busy;
	logic [7:0]  card_preset;
	logic [7:0]  card_rx;
	int          card_rises;
	logic [15:0] lfsr_state;
	logic        exp_zx_cs_n;
	logic        exp_avr_cs_n;
	logic [7:0]  exp_zx_out;
	logic [7:0]  exp_avr_out;

	sd_spi_hub #(.HALF_PERIOD(HALF_PERIOD)) sd_spi_hub_inst (.*);

	sd_card_model sd_card_model_inst
	(
		.sdcs_n     (sdcs_n),
		.sdclk      (sdclk),
		.sddo       (sddo),
		.preset     (card_preset),
		.sddi       (sddi),
		.rx_byte    (card_rx),
		.rise_count (card_rises)
	);

	initial
	begin
		fclk = 1'b0;
		forever #50 fclk = ~fclk;
	end

	//////////////////////////////
	// reporting
	//////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		abort_run($sformatf("mismatch at %0t: %s is 0x%0h, expected 0x%0h",
			$time, name, got, expected));
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got == expected)
		else
			report_mismatch(name, got, expected);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_random_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	//////////////////////////////
	// chip select reference and checks
	//////////////////////////////

	always @(posedge fclk)
	begin
		if (reset)
		begin
			exp_zx_cs_n  <= 1'b1;
			exp_avr_cs_n <= 1'b1;
		end
		else
		begin
			if (zx_cs_n_stb)
				exp_zx_cs_n <= zx_cs_n_val;
			exp_avr_cs_n <= avr_cs_n;
		end
	end

	cs_follows_owner: assert property (@(posedge fclk) disable iff (reset)
		sdcs_n == (avr_lock_grant ? exp_avr_cs_n : exp_zx_cs_n))
	else
		report_mismatch("sdcs_n", 32'($sampled(sdcs_n)),
			32'($sampled(avr_lock_grant) ? $sampled(exp_avr_cs_n) :
				$sampled(exp_zx_cs_n)));

	release_next_cycle: assert property (@(posedge fclk) disable iff (reset)
		!avr_lock_claim |=> !avr_lock_grant)
	else
		abort_run("avr_lock_grant still high one cycle after the claim dropped");

	grant_on_idle: assert property (@(posedge fclk) disable iff (reset)
		$rose(avr_lock_grant) |-> $past(avr_lock_claim) && !$past(sd_busy))
	else
		abort_run("avr_lock_grant rose without a claim on an idle shifter");

	sdclk_in_transfer: assert property (@(posedge fclk) disable iff (reset)
		sdclk |-> sd_busy)
	else
		abort_run("sdclk high while the shifter is not busy");

	sddo_on_low_clock: assert property (@(posedge fclk) disable iff (reset)
		(sddo != $past(sddo)) |-> !sdclk)
	else
		abort_run("sddo changed while sdclk was high");

	//////////////////////////////
	// stimulus tasks
	//////////////////////////////

	task automatic check_reset_state();
		check_value("sdcs_n", 32'(sdcs_n), 32'd1);
		check_value("zx chip select", 32'(sd_spi_hub_inst.zx_cmd.cs_n), 32'd1);
		check_value("avr chip select", 32'(sd_spi_hub_inst.avr_cmd.cs_n), 32'd1);
		check_value("shift_start", 32'(sd_spi_hub_inst.shift_start), 32'd0);
		check_value("done", 32'(sd_spi_hub_inst.done), 32'd0);
		check_value("sdclk", 32'(sdclk), 32'd0);
		check_value("sddo", 32'(sddo), 32'd0);
		check_value("sd_busy", 32'(sd_busy), 32'd0);
		check_value("avr_lock_grant", 32'(avr_lock_grant), 32'd0);
		check_value("zx_dataout", 32'(zx_dataout), 32'hFF);
		check_value("avr_dataout", 32'(avr_dataout), 32'hFF);
	endtask

	task automatic set_zx_cs(input logic level);
		@(posedge fclk);
		zx_cs_n_val <= level;
		zx_cs_n_stb <= 1'b1;
		@(posedge fclk);
		zx_cs_n_stb <= 1'b0;
	endtask

	// grant follows the claim one cycle later on an idle shifter
	task automatic change_claim(input logic level);
		@(posedge fclk);
		avr_lock_claim <= level;
		@(negedge fclk);
		check_value("avr_lock_grant", 32'(avr_lock_grant), 32'(!level));
		@(negedge fclk);
		check_value("avr_lock_grant", 32'(avr_lock_grant), 32'(level));
	endtask

	task automatic run_transfer(input logic from_avr, input logic flip_claim);
		logic [7:0] tx;
		logic [7:0] card_byte;
		logic       exp_grant;
		int         rises_before;
		int         busy_cycles;
		take_random_byte(tx);
		take_random_byte(card_byte);
		@(posedge fclk);
		card_preset <= card_byte;
		zx_start    <= !from_avr;
		avr_start   <= from_avr;
		zx_datain   <= tx;
		avr_datain  <= tx;
		rises_before = card_rises;
		busy_cycles  = 0;
		@(posedge fclk);
		zx_start  <= 1'b0;
		avr_start <= 1'b0;
		// one cycle in the port before the shifter goes busy
		@(negedge fclk);
		check_value("sd_busy", 32'(sd_busy), 32'd0);
		@(negedge fclk);
		check_value("sd_busy", 32'(sd_busy), 32'd1);
		while (sd_busy)
		begin
			busy_cycles++;
			// a dropped claim takes the grant away one cycle later
			exp_grant = from_avr && !(flip_claim && busy_cycles > 2);
			check_value("avr_lock_grant", 32'(avr_lock_grant), 32'(exp_grant));
			@(posedge fclk);
			// claim flips while the byte is in flight
			if (flip_claim)
				avr_lock_claim <= !from_avr;
			@(negedge fclk);
		end
		check_value("sd_busy high cycles", busy_cycles, 16 * HALF_PERIOD);
		if (from_avr)
			exp_avr_out = card_byte;
		else
			exp_zx_out = card_byte;
		// read-back lands one cycle after done
		@(negedge fclk);
		check_value("card rx byte", 32'(card_rx), 32'(tx));
		check_value("sdclk rising edges", card_rises - rises_before, 8);
		check_value("zx_dataout", 32'(zx_dataout), 32'(exp_zx_out));
		check_value("avr_dataout", 32'(avr_dataout), 32'(exp_avr_out));
		check_value("avr_lock_grant", 32'(avr_lock_grant), 32'(from_avr ^ flip_claim));
	endtask

	task automatic drop_zx_start();
		logic [7:0] tx;
		take_random_byte(tx);
		@(posedge fclk);
		zx_start  <= 1'b1;
		zx_datain <= tx;
		@(posedge fclk);
		zx_start <= 1'b0;
		repeat (4)
		begin
			@(negedge fclk);
			check_value("sd_busy", 32'(sd_busy), 32'd0);
		end
		check_value("zx_dataout", 32'(zx_dataout), 32'(exp_zx_out));
	endtask

	initial
	begin
		$timeformat(-9, 0, " ns", 0);
		reset          = 1'b1;
		zx_cs_n_val    = 1'b1;
		zx_cs_n_stb    = 1'b0;
		zx_start       = 1'b0;
		zx_datain      = 8'h00;
		avr_lock_claim = 1'b0;
		avr_cs_n       = 1'b1;
		avr_start      = 1'b0;
		avr_datain     = 8'h00;
		card_preset    = 8'hFF;
		exp_zx_out     = 8'hFF;
		exp_avr_out    = 8'hFF;
		lfsr_state     = 16'd22;
		repeat (2) @(posedge fclk);
		@(negedge fclk);
		check_reset_state();
		repeat (6) @(posedge fclk);
		reset <= 1'b0;
		@(negedge fclk);
		check_reset_state();

		// z80 owns the card out of reset
		set_zx_cs(1'b0);
		run_transfer(1'b0, 1'b0);

		// card select comes from avr_cs_n under the lock
		change_claim(1'b1);
		check_value("sdcs_n", 32'(sdcs_n), 32'd1);
		@(posedge fclk);
		avr_cs_n <= 1'b0;
		drop_zx_start();
		run_transfer(1'b1, 1'b0);

		// the release returns the z80 select and its starts
		@(posedge fclk);
		avr_cs_n <= 1'b1;
		change_claim(1'b0);
		check_value("sdcs_n", 32'(sdcs_n), 32'd0);
		run_transfer(1'b0, 1'b0);

		// claim in mid transfer waits for the shifter
		run_transfer(1'b0, 1'b1);

		// a release in mid transfer still reports to the microcontroller
		@(posedge fclk);
		avr_cs_n <= 1'b0;
		run_transfer(1'b1, 1'b1);

		$display("Finished with no errors");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge fclk);
		abort_run($sformatf("timeout: run did not end within %0d cycles", WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire
